/* decode_function.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_function (
	input wire decode_pkg::inst_t inst,
	output decode_pkg::unit_sel_t unit,
	output decode_pkg::opcode_t opcode,
	output decode_pkg::reg_idx_t destination,
	output decode_pkg::reg_idx_t source0,
	output decode_pkg::data_t source1,
	output logic source1_imm,
	output logic writeback,
	output logic fault_invalid
);

	// Fixed instruction fields
	assign opcode = inst[31:27];
	assign destination = inst[26:22];
	assign source0 = inst[21:17];
	assign source1_imm = inst[16];

	// Immediate is signed, register index is a plain number
	always_comb begin
		if (source1_imm) begin
			source1 = {{16{inst[15]}}, inst[15:0]};
		end else begin
			source1 = {27'b0, inst[4:0]};
		end
	end

	// Opcode class to one-hot unit
	always_comb begin
		unit = '0;
		fault_invalid = 1'b0;
		if (opcode <= decode_pkg::OPC_LOGIC_LAST) begin
			unit[decode_pkg::UNIT_LOGIC] = 1'b1;
		end else if (opcode <= decode_pkg::OPC_SHIFT_LAST) begin
			unit[decode_pkg::UNIT_SHIFT] = 1'b1;
		end else if (opcode <= decode_pkg::OPC_ADDER_LAST) begin
			unit[decode_pkg::UNIT_ADDER] = 1'b1;
		end else if (opcode == decode_pkg::OPC_MUL) begin
			unit[decode_pkg::UNIT_MUL] = 1'b1;
		end else if (opcode == decode_pkg::OPC_SDIV) begin
			unit[decode_pkg::UNIT_SDIV] = 1'b1;
		end else if (opcode == decode_pkg::OPC_UDIV) begin
			unit[decode_pkg::UNIT_UDIV] = 1'b1;
		end else if (opcode <= decode_pkg::OPC_LOAD_LAST) begin
			unit[decode_pkg::UNIT_LOAD] = 1'b1;
		end else if (opcode <= decode_pkg::OPC_STORE_LAST) begin
			unit[decode_pkg::UNIT_STORE] = 1'b1;
		end else if (opcode <= decode_pkg::OPC_BRANCH_LAST) begin
			unit[decode_pkg::UNIT_BRANCH] = 1'b1;
		end else begin
			// Unused opcode space
			fault_invalid = 1'b1;
		end
	end

	// Store and branch write no register
	always_comb begin
		writeback = 1'b1;
		if (fault_invalid) begin
			writeback = 1'b0;
		end else if (unit[decode_pkg::UNIT_STORE] || unit[decode_pkg::UNIT_BRANCH]) begin
			writeback = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* decode_pkg.sv */
`default_nettype none

package decode_pkg;

	// Front-end geometry
	localparam int DECODE_LANES = 2;
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

	// Unit select width and bit positions
	localparam int UNIT_COUNT = 9;
	localparam int UNIT_LOGIC = 0;
	localparam int UNIT_SHIFT = 1;
	localparam int UNIT_ADDER = 2;
	localparam int UNIT_MUL = 3;
	localparam int UNIT_SDIV = 4;
	localparam int UNIT_UDIV = 5;
	localparam int UNIT_LOAD = 6;
	localparam int UNIT_STORE = 7;
	localparam int UNIT_BRANCH = 8;

	typedef logic [31:0] inst_t;
	typedef logic [31:0] pc_t;
	typedef logic [4:0] opcode_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] data_t;
	typedef logic [UNIT_COUNT-1:0] unit_sel_t;

	// Queue pointer and occupancy
	typedef logic [QUEUE_PTR_W-1:0] q_ptr_t;
	typedef logic [QUEUE_PTR_W:0] q_count_t;

	// Opcode classes, checked in ascending order
	localparam opcode_t OPC_LOGIC_LAST = 5'd3;
	localparam opcode_t OPC_SHIFT_LAST = 5'd7;
	localparam opcode_t OPC_ADDER_LAST = 5'd11;
	localparam opcode_t OPC_MUL = 5'd12;
	localparam opcode_t OPC_SDIV = 5'd13;
	localparam opcode_t OPC_UDIV = 5'd14;
	localparam opcode_t OPC_LOAD_LAST = 5'd16;
	localparam opcode_t OPC_STORE_LAST = 5'd18;
	localparam opcode_t OPC_BRANCH_LAST = 5'd22;

endpackage

`default_nettype wire

/* decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_top (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	// Fetch
	input wire fetch_valid,
	input wire decode_pkg::inst_t fetch_inst,
	input wire decode_pkg::pc_t fetch_pc,
	input wire fetch_pagefault,
	output wire fetch_lock,
	// Issue
	output wire issue_valid,
	output wire decode_pkg::unit_sel_t issue_unit,
	output wire decode_pkg::opcode_t issue_opcode,
	output wire decode_pkg::reg_idx_t issue_destination,
	output wire decode_pkg::reg_idx_t issue_source0,
	output wire decode_pkg::data_t issue_source1,
	output wire issue_source1_imm,
	output wire issue_writeback,
	output wire issue_fault_invalid,
	output wire issue_fault_pagefault,
	output wire decode_pkg::pc_t issue_pc,
	input wire issue_lock
);

	// Queue to lanes
	wire [decode_pkg::DECODE_LANES-1:0] lane_in_valid;
	wire decode_pkg::inst_t lane_in_inst [decode_pkg::DECODE_LANES];
	wire decode_pkg::pc_t lane_in_pc [decode_pkg::DECODE_LANES];
	wire [decode_pkg::DECODE_LANES-1:0] lane_in_pagefault;
	wire [decode_pkg::DECODE_LANES-1:0] lane_in_lock;

	// Lanes to serializer
	wire [decode_pkg::DECODE_LANES-1:0] lane_out_valid;
	wire decode_pkg::unit_sel_t lane_unit [decode_pkg::DECODE_LANES];
	wire decode_pkg::opcode_t lane_opcode [decode_pkg::DECODE_LANES];
	wire decode_pkg::reg_idx_t lane_destination [decode_pkg::DECODE_LANES];
	wire decode_pkg::reg_idx_t lane_source0 [decode_pkg::DECODE_LANES];
	wire decode_pkg::data_t lane_source1 [decode_pkg::DECODE_LANES];
	wire [decode_pkg::DECODE_LANES-1:0] lane_source1_imm;
	wire [decode_pkg::DECODE_LANES-1:0] lane_writeback;
	wire [decode_pkg::DECODE_LANES-1:0] lane_fault_invalid;
	wire [decode_pkg::DECODE_LANES-1:0] lane_fault_pagefault;
	wire decode_pkg::pc_t lane_pc [decode_pkg::DECODE_LANES];
	wire lane_lock;

	inst_fetch_queue u_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.fetch_valid(fetch_valid),
		.fetch_inst(fetch_inst),
		.fetch_pc(fetch_pc),
		.fetch_pagefault(fetch_pagefault),
		.fetch_lock(fetch_lock),
		.lane_valid(lane_in_valid),
		.lane_inst(lane_in_inst),
		.lane_pc(lane_in_pc),
		.lane_pagefault(lane_in_pagefault),
		// All lanes pass the same lock, lane 0 stands for them
		.lane_lock(lane_in_lock[0])
	);

	for (genvar i = 0; i < decode_pkg::DECODE_LANES; i++) begin : g_lane
		decoder u_decoder (
			.iCLOCK(iCLOCK),
			.inRESET(inRESET),
			.flush(flush),
			.in_valid(lane_in_valid[i]),
			.in_inst(lane_in_inst[i]),
			.in_pc(lane_in_pc[i]),
			.in_pagefault(lane_in_pagefault[i]),
			.in_lock(lane_in_lock[i]),
			.out_valid(lane_out_valid[i]),
			.out_unit(lane_unit[i]),
			.out_opcode(lane_opcode[i]),
			.out_destination(lane_destination[i]),
			.out_source0(lane_source0[i]),
			.out_source1(lane_source1[i]),
			.out_source1_imm(lane_source1_imm[i]),
			.out_writeback(lane_writeback[i]),
			.out_fault_invalid(lane_fault_invalid[i]),
			.out_pagefault(lane_fault_pagefault[i]),
			.out_pc(lane_pc[i]),
			.out_lock(lane_lock)
		);
	end

	issue_serializer u_serializer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.lane_valid(lane_out_valid),
		.lane_unit(lane_unit),
		.lane_opcode(lane_opcode),
		.lane_destination(lane_destination),
		.lane_source0(lane_source0),
		.lane_source1(lane_source1),
		.lane_source1_imm(lane_source1_imm),
		.lane_writeback(lane_writeback),
		.lane_fault_invalid(lane_fault_invalid),
		.lane_fault_pagefault(lane_fault_pagefault),
		.lane_pc(lane_pc),
		.lane_lock(lane_lock),
		.issue_valid(issue_valid),
		.issue_unit(issue_unit),
		.issue_opcode(issue_opcode),
		.issue_destination(issue_destination),
		.issue_source0(issue_source0),
		.issue_source1(issue_source1),
		.issue_source1_imm(issue_source1_imm),
		.issue_writeback(issue_writeback),
		.issue_fault_invalid(issue_fault_invalid),
		.issue_fault_pagefault(issue_fault_pagefault),
		.issue_pc(issue_pc),
		.issue_lock(issue_lock)
	);

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module decoder (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	// Upstream side
	input wire in_valid,
	input wire decode_pkg::inst_t in_inst,
	input wire decode_pkg::pc_t in_pc,
	input wire in_pagefault,
	output logic in_lock,
	// Downstream side
	output logic out_valid,
	output decode_pkg::unit_sel_t out_unit,
	output decode_pkg::opcode_t out_opcode,
	output decode_pkg::reg_idx_t out_destination,
	output decode_pkg::reg_idx_t out_source0,
	output decode_pkg::data_t out_source1,
	output logic out_source1_imm,
	output logic out_writeback,
	output logic out_fault_invalid,
	output logic out_pagefault,
	output decode_pkg::pc_t out_pc,
	input wire out_lock
);

	decode_pkg::unit_sel_t dec_unit;
	decode_pkg::opcode_t dec_opcode;
	decode_pkg::reg_idx_t dec_destination;
	decode_pkg::reg_idx_t dec_source0;
	decode_pkg::data_t dec_source1;
	logic dec_source1_imm;
	logic dec_writeback;
	logic dec_fault_invalid;

	logic b_valid;

	decode_function u_decode_function (
		.inst(in_inst),
		.unit(dec_unit),
		.opcode(dec_opcode),
		.destination(dec_destination),
		.source0(dec_source0),
		.source1(dec_source1),
		.source1_imm(dec_source1_imm),
		.writeback(dec_writeback),
		.fault_invalid(dec_fault_invalid)
	);

	// Valid bit, dropped by flush
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_valid <= 1'b0;
		end else if (flush) begin
			b_valid <= 1'b0;
		end else if (!out_lock) begin
			b_valid <= in_valid;
		end
	end

	// Decoded fields, only meaningful with out_valid
	always_ff @(posedge iCLOCK) begin
		if (!out_lock) begin
			out_unit <= dec_unit;
			out_opcode <= dec_opcode;
			out_destination <= dec_destination;
			out_source0 <= dec_source0;
			out_source1 <= dec_source1;
			out_source1_imm <= dec_source1_imm;
			out_writeback <= dec_writeback;
			out_fault_invalid <= dec_fault_invalid;
			out_pagefault <= in_pagefault;
			out_pc <= in_pc;
		end
	end

	assign out_valid = b_valid;

	// Stage holds whenever the next one holds
	assign in_lock = out_lock;

endmodule

`default_nettype wire

/* inst_fetch_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_fetch_queue (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	// Fetch side
	input wire fetch_valid,
	input wire decode_pkg::inst_t fetch_inst,
	input wire decode_pkg::pc_t fetch_pc,
	input wire fetch_pagefault,
	output logic fetch_lock,
	// Lane side, entry 0 is the oldest
	output logic [decode_pkg::DECODE_LANES-1:0] lane_valid,
	output decode_pkg::inst_t lane_inst [decode_pkg::DECODE_LANES],
	output decode_pkg::pc_t lane_pc [decode_pkg::DECODE_LANES],
	output logic [decode_pkg::DECODE_LANES-1:0] lane_pagefault,
	input wire lane_lock
);

	decode_pkg::inst_t mem_inst [decode_pkg::QUEUE_DEPTH];
	decode_pkg::pc_t mem_pc [decode_pkg::QUEUE_DEPTH];
	logic mem_pagefault [decode_pkg::QUEUE_DEPTH];

	decode_pkg::q_ptr_t head;
	decode_pkg::q_ptr_t tail;
	decode_pkg::q_count_t count;
	decode_pkg::q_count_t pop_count;
	logic push;

	// Oldest entries go straight to the lanes
	always_comb begin
		for (int i = 0; i < decode_pkg::DECODE_LANES; i++) begin
			lane_valid[i] = count > decode_pkg::q_count_t'(i);
			lane_inst[i] = mem_inst[head + decode_pkg::q_ptr_t'(i)];
			lane_pc[i] = mem_pc[head + decode_pkg::q_ptr_t'(i)];
			lane_pagefault[i] = mem_pagefault[head + decode_pkg::q_ptr_t'(i)];
		end
	end

	// Lanes take everything shown to them unless locked
	always_comb begin
		if (lane_lock) begin
			pop_count = '0;
		end else if (count >= decode_pkg::q_count_t'(decode_pkg::DECODE_LANES)) begin
			pop_count = decode_pkg::q_count_t'(decode_pkg::DECODE_LANES);
		end else begin
			pop_count = count;
		end
	end

	assign fetch_lock = (count == decode_pkg::q_count_t'(decode_pkg::QUEUE_DEPTH)) &&
		(pop_count == '0);
	assign push = fetch_valid && !fetch_lock;

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem_inst[tail] <= fetch_inst;
			mem_pc[tail] <= fetch_pc;
			mem_pagefault[tail] <= fetch_pagefault;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (flush) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			head <= head + decode_pkg::q_ptr_t'(pop_count);
			tail <= tail + decode_pkg::q_ptr_t'(push);
			count <= count + decode_pkg::q_count_t'(push) - pop_count;
		end
	end

endmodule

`default_nettype wire

/* issue_serializer.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_serializer (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	// Decoded lanes
	input wire [decode_pkg::DECODE_LANES-1:0] lane_valid,
	input wire decode_pkg::unit_sel_t lane_unit [decode_pkg::DECODE_LANES],
	input wire decode_pkg::opcode_t lane_opcode [decode_pkg::DECODE_LANES],
	input wire decode_pkg::reg_idx_t lane_destination [decode_pkg::DECODE_LANES],
	input wire decode_pkg::reg_idx_t lane_source0 [decode_pkg::DECODE_LANES],
	input wire decode_pkg::data_t lane_source1 [decode_pkg::DECODE_LANES],
	input wire [decode_pkg::DECODE_LANES-1:0] lane_source1_imm,
	input wire [decode_pkg::DECODE_LANES-1:0] lane_writeback,
	input wire [decode_pkg::DECODE_LANES-1:0] lane_fault_invalid,
	input wire [decode_pkg::DECODE_LANES-1:0] lane_fault_pagefault,
	input wire decode_pkg::pc_t lane_pc [decode_pkg::DECODE_LANES],
	output logic lane_lock,
	// Issue stream
	output logic issue_valid,
	output decode_pkg::unit_sel_t issue_unit,
	output decode_pkg::opcode_t issue_opcode,
	output decode_pkg::reg_idx_t issue_destination,
	output decode_pkg::reg_idx_t issue_source0,
	output decode_pkg::data_t issue_source1,
	output logic issue_source1_imm,
	output logic issue_writeback,
	output logic issue_fault_invalid,
	output logic issue_fault_pagefault,
	output decode_pkg::pc_t issue_pc,
	input wire issue_lock
);

	typedef enum logic {
		take_pair,
		take_second
	} state_t;

	state_t state;
	state_t state_next;
	logic sel;
	logic pair_split;

	// Lane 1 waits one cycle behind lane 0
	assign sel = (state == take_second);
	assign pair_split = (state == take_pair) && lane_valid[1];

	// Lanes hold while the second half of a pair is pending
	assign lane_lock = issue_lock || pair_split;

	always_comb begin
		state_next = state;
		if (!issue_lock) begin
			state_next = pair_split ? take_second : take_pair;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= take_pair;
			issue_valid <= 1'b0;
		end else if (flush) begin
			state <= take_pair;
			issue_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (!issue_lock) begin
				issue_valid <= lane_valid[sel];
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!issue_lock) begin
			issue_unit <= lane_unit[sel];
			issue_opcode <= lane_opcode[sel];
			issue_destination <= lane_destination[sel];
			issue_source0 <= lane_source0[sel];
			issue_source1 <= lane_source1[sel];
			issue_source1_imm <= lane_source1_imm[sel];
			issue_writeback <= lane_writeback[sel];
			issue_fault_invalid <= lane_fault_invalid[sel];
			issue_fault_pagefault <= lane_fault_pagefault[sel];
			issue_pc <= lane_pc[sel];
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the decode front testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module tb_decode_top -o tb_sim; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if echo "$out" | grep -q "all tests passed"; then
	exit 0
fi
exit 1

/* tb.f */
+incdir+.
decode_pkg.sv
decode_function.sv
decoder.sv
inst_fetch_queue.sv
issue_serializer.sv
decode_top.sv
tb_decode_top.sv

/* tb_decode_ref.svh */
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH
`default_nettype none

typedef struct packed {
	decode_pkg::unit_sel_t unit;
	decode_pkg::opcode_t opcode;
	decode_pkg::reg_idx_t destination;
	decode_pkg::reg_idx_t source0;
	decode_pkg::data_t source1;
	logic source1_imm;
	logic writeback;
	logic fault_invalid;
	logic fault_pagefault;
	decode_pkg::pc_t pc;
} expected_t;

// Accepted but not yet issued, oldest first
expected_t expected_q[$];

function automatic expected_t ref_decode(decode_pkg::inst_t inst, decode_pkg::pc_t pc,
	logic pagefault);
	expected_t e;
	int unit_bit;
	case (inst[31:27]) inside
		[5'd0:5'd3]: unit_bit = 0;
		[5'd4:5'd7]: unit_bit = 1;
		[5'd8:5'd11]: unit_bit = 2;
		5'd12: unit_bit = 3;
		5'd13: unit_bit = 4;
		5'd14: unit_bit = 5;
		[5'd15:5'd16]: unit_bit = 6;
		[5'd17:5'd18]: unit_bit = 7;
		[5'd19:5'd22]: unit_bit = 8;
		default: unit_bit = -1;
	endcase
	e.unit = (unit_bit < 0) ? '0 : decode_pkg::unit_sel_t'(1) << unit_bit;
	e.fault_invalid = (unit_bit < 0);
	// Store and branch sit on bits 7 and 8
	e.writeback = (unit_bit >= 0) && (unit_bit <= 6);
	e.opcode = inst[31:27];
	e.destination = inst[26:22];
	e.source0 = inst[21:17];
	e.source1_imm = inst[16];
	// Signed 16-bit immediate or a bare register number
	if (inst[16]) begin
		e.source1 = int'($signed(inst[15:0]));
	end else begin
		e.source1 = decode_pkg::data_t'(inst[4:0]);
	end
	e.fault_pagefault = pagefault;
	e.pc = pc;
	return e;
endfunction

task automatic push_expected(decode_pkg::inst_t inst, decode_pkg::pc_t pc, logic pagefault);
	expected_q.push_back(ref_decode(inst, pc, pagefault));
endtask

task automatic clear_expected();
	expected_q.delete();
endtask

function automatic int expected_count();
	return expected_q.size();
endfunction

task automatic check_issue();
	expected_t e;
	if (expected_q.size() == 0) begin
		abort_run($sformatf("instruction at pc %h issued at %0t but none was pending",
			issue_pc, $time));
	end else begin
		e = expected_q.pop_front();
		check_pc("issue_pc", issue_pc, e.pc);
		check_opcode("issue_opcode", issue_opcode, e.opcode);
		check_unit("issue_unit", issue_unit, e.unit);
		check_reg("issue_destination", issue_destination, e.destination);
		check_reg("issue_source0", issue_source0, e.source0);
		check_data("issue_source1", issue_source1, e.source1);
		check_flag("issue_source1_imm", issue_source1_imm, e.source1_imm);
		check_flag("issue_writeback", issue_writeback, e.writeback);
		check_flag("issue_fault_invalid", issue_fault_invalid, e.fault_invalid);
		check_flag("issue_fault_pagefault", issue_fault_pagefault, e.fault_pagefault);
	end
endtask

`default_nettype wire
`endif

/* tb_decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_decode_top;

	localparam int NUM_TESTS = 400;
	localparam int CYCLE_LIMIT = 20 * NUM_TESTS;
	localparam logic [31:0] SEED = 32'd80;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic fetch_valid;
	decode_pkg::inst_t fetch_inst;
	decode_pkg::pc_t fetch_pc;
	logic fetch_pagefault;
	logic fetch_lock;
	logic issue_valid;
	decode_pkg::unit_sel_t issue_unit;
	decode_pkg::opcode_t issue_opcode;
	decode_pkg::reg_idx_t issue_destination;
	decode_pkg::reg_idx_t issue_source0;
	decode_pkg::data_t issue_source1;
	logic issue_source1_imm;
	logic issue_writeback;
	logic issue_fault_invalid;
	logic issue_fault_pagefault;
	decode_pkg::pc_t issue_pc;
	logic issue_lock;

	logic [31:0] rng_state = SEED;
	int cycle_count = 0;
	int accepted_count = 0;
	decode_pkg::pc_t next_pc = 32'h0000_1000;
	logic saw_fetch_lock = 1'b0;

	// Issue outputs seen on a locked edge
	logic hold_pending = 1'b0;
	logic hold_valid;
	decode_pkg::pc_t hold_pc;
	decode_pkg::opcode_t hold_opcode;
	decode_pkg::unit_sel_t hold_unit;
	decode_pkg::reg_idx_t hold_destination;
	decode_pkg::reg_idx_t hold_source0;
	decode_pkg::data_t hold_source1;
	logic hold_source1_imm;
	logic hold_writeback;
	logic hold_fault_invalid;
	logic hold_fault_pagefault;

	decode_top uut (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	// Run limit
	always @(posedge iCLOCK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			abort_run($sformatf("timeout after %0d cycles with %0d instructions still expected",
				cycle_count, expected_count()));
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_unit(string name, decode_pkg::unit_sel_t got,
		decode_pkg::unit_sel_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_opcode(string name, decode_pkg::opcode_t got, decode_pkg::opcode_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_reg(string name, decode_pkg::reg_idx_t got, decode_pkg::reg_idx_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_data(string name, decode_pkg::data_t got, decode_pkg::data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_pc(string name, decode_pkg::pc_t got, decode_pkg::pc_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	// Called 10 ns after a rising edge
	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] w0;
		logic [31:0] w1;
		r = next_rand();
		w0 = next_rand();
		w1 = next_rand();
		flush = (r[31:24] < 8'd3);
		issue_lock = (r[23:21] < 3'd3);
		fetch_valid = (r[20:19] != 2'd0);
		fetch_pagefault = (r[18:16] == 3'd0);
		fetch_inst = {w0[31:16], w1[31:16]};
		fetch_pc = next_pc;
	endtask

	task automatic drive_idle();
		flush = 1'b0;
		issue_lock = 1'b0;
		fetch_valid = 1'b0;
	endtask

	// Mid-cycle view of what the coming edge does
	task automatic monitor_edge();
		@(negedge iCLOCK);
		if (fetch_lock) begin
			saw_fetch_lock = 1'b1;
		end
		if (hold_pending) begin
			check_flag("issue_valid held", issue_valid, hold_valid);
			check_pc("issue_pc held", issue_pc, hold_pc);
			check_opcode("issue_opcode held", issue_opcode, hold_opcode);
			check_unit("issue_unit held", issue_unit, hold_unit);
			check_reg("issue_destination held", issue_destination, hold_destination);
			check_reg("issue_source0 held", issue_source0, hold_source0);
			check_data("issue_source1 held", issue_source1, hold_source1);
			check_flag("issue_source1_imm held", issue_source1_imm, hold_source1_imm);
			check_flag("issue_writeback held", issue_writeback, hold_writeback);
			check_flag("issue_fault_invalid held", issue_fault_invalid, hold_fault_invalid);
			check_flag("issue_fault_pagefault held", issue_fault_pagefault,
				hold_fault_pagefault);
		end
		hold_pending = issue_lock && !flush;
		hold_valid = issue_valid;
		hold_pc = issue_pc;
		hold_opcode = issue_opcode;
		hold_unit = issue_unit;
		hold_destination = issue_destination;
		hold_source0 = issue_source0;
		hold_source1 = issue_source1;
		hold_source1_imm = issue_source1_imm;
		hold_writeback = issue_writeback;
		hold_fault_invalid = issue_fault_invalid;
		hold_fault_pagefault = issue_fault_pagefault;
		if (issue_valid && !issue_lock) begin
			check_issue();
		end
		if (flush) begin
			clear_expected();
		end else if (fetch_valid && !fetch_lock) begin
			push_expected(fetch_inst, fetch_pc, fetch_pagefault);
		end
		if (fetch_valid && !fetch_lock) begin
			accepted_count++;
			next_pc = next_pc + 32'd4;
		end
	endtask

	initial begin
		inRESET = 1'b0;
		flush = 1'b0;
		fetch_valid = 1'b0;
		fetch_inst = '0;
		fetch_pc = '0;
		fetch_pagefault = 1'b0;
		issue_lock = 1'b0;
		repeat (7) @(posedge iCLOCK);
		@(negedge iCLOCK);
		check_flag("issue_valid in reset", issue_valid, 1'b0);
		check_flag("fetch_lock in reset", fetch_lock, 1'b0);
		@(posedge iCLOCK);
		#10 inRESET = 1'b1;
		@(negedge iCLOCK);
		check_flag("issue_valid after reset", issue_valid, 1'b0);
		check_flag("fetch_lock after reset", fetch_lock, 1'b0);
		while (accepted_count < NUM_TESTS) begin
			@(posedge iCLOCK);
			#10;
			drive_random();
			monitor_edge();
		end
		// Let everything drain, then watch for stray issues
		@(posedge iCLOCK);
		#10;
		drive_idle();
		while (expected_count() != 0) begin
			monitor_edge();
		end
		repeat (8) monitor_edge();
		if (!saw_fetch_lock) begin
			abort_run("fetch_lock never rose, the queue was never seen full");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

	`include "tb_decode_ref.svh"

endmodule

`default_nettype wire
